// File: verilog/capture_cfg.svh
`ifndef CAPTURE_CFG_SVH
`define CAPTURE_CFG_SVH

// ===========================================================================
// Capture path sizing
// ===========================================================================

// One incoming sample
`define CAP_SAMPLE_W 8

// Buffer word holds two samples
`define CAP_WORD_W 16

// 64 words split into two banks of 32
`define CAP_ADDR_W 6

// Header fields in the first word of each bank
`define CAP_SEQ_W 8
`define CAP_DROP_W 8

`endif

// File: verilog/capture_pkg.sv
`default_nettype none

`include "capture_cfg.svh"

package capture_pkg;

    // Input stream element
    typedef struct packed {
        logic                     valid;
        logic [`CAP_SAMPLE_W-1:0] data;
    } sample_t;

    // Header view of a buffer word
    typedef struct packed {
        logic [`CAP_SEQ_W-1:0]  seq;
        logic [`CAP_DROP_W-1:0] drops;
    } cap_header_t;

    // Payload view, older sample in the high byte
    typedef struct packed {
        logic [`CAP_SAMPLE_W-1:0] first;
        logic [`CAP_SAMPLE_W-1:0] second;
    } cap_payload_t;

    // Slot 0 of a bank is a header, all other slots are payload
    typedef union packed {
        cap_header_t  hdr;
        cap_payload_t pay;
    } cap_word_t;

    // One output beat
    typedef struct packed {
        logic      valid;
        logic      start;
        logic      last;
        cap_word_t word;
    } frame_beat_t;

endpackage

`default_nettype wire

// File: verilog/sample_packer.sv
`default_nettype none

`include "capture_cfg.svh"

module sample_packer (
    input  logic                   r_clk,
    input  logic                   fullish,
    input  capture_pkg::sample_t   sample_in,
    input  logic                   w_ready,
    input  logic                   w_bank_start,
    output logic                   w_trigger,
    output capture_pkg::cap_word_t w_data
);
    import capture_pkg::*;

    logic [`CAP_SAMPLE_W-1:0] first_q;
    logic                     have_first;
    cap_word_t                pair_q;
    logic                     pair_v;
    logic                     hdr_sent;
    logic [`CAP_SEQ_W-1:0]    seq_q;
    logic [`CAP_DROP_W-1:0]   drop_q;
    cap_word_t                hdr_word;
    logic                     pair_done;
    logic                     hdr_write;
    logic                     pair_write;
    logic                     pair_drop;

    // Second sample of a pair arrives this cycle
    assign pair_done = sample_in.valid && have_first;

    // At a bank start the header goes first, pair follows a cycle later
    assign hdr_write  = pair_v && !hdr_sent && w_bank_start && w_ready;
    assign pair_drop  = pair_v && !hdr_sent && w_bank_start && !w_ready;
    // Mid-bank the writer always has room
    assign pair_write = pair_v && (hdr_sent || !w_bank_start);

    always_comb begin
        hdr_word.hdr.seq   = seq_q;
        hdr_word.hdr.drops = drop_q;
    end

    assign w_trigger = hdr_write || pair_write;
    assign w_data    = hdr_write ? hdr_word : pair_q;

    // Sample data registers
    always_ff @(posedge r_clk) begin
        if (sample_in.valid && !have_first) begin
            first_q <= sample_in.data;
        end
        if (pair_done) begin
            pair_q.pay.first  <= first_q;
            pair_q.pay.second <= sample_in.data;
        end
    end

    // Pairing state, header bookkeeping and drop counting
    always_ff @(posedge r_clk or posedge fullish) begin
        if (fullish) begin
            have_first <= 1'b0;
            pair_v     <= 1'b0;
            hdr_sent   <= 1'b0;
            seq_q      <= '0;
            drop_q     <= '0;
        end else begin
            if (sample_in.valid) begin
                have_first <= !have_first;
            end
            if (pair_done) begin
                pair_v <= 1'b1;
            end else if (pair_write || pair_drop) begin
                pair_v <= 1'b0;
            end
            hdr_sent <= hdr_write;
            if (hdr_write) begin
                seq_q  <= seq_q + 1'b1;
                drop_q <= '0;
            end else if (pair_drop && drop_q != '1) begin
                // Saturates at all ones
                drop_q <= drop_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/bank_fifo.sv
`default_nettype none

module bank_fifo #(
    parameter int W = 16,
    parameter int N = 6
) (
    input  logic         r_clk,
    input  logic         fullish,
    input  logic         w_trigger,
    input  logic [W-1:0] w_data,
    output logic         w_ready,
    output logic         w_bank_start,
    input  logic         r_trigger,
    output logic         r_ready,
    output logic [W-1:0] r_data
);
    localparam int DEPTH = 1 << N;

    logic [W-1:0] mem [DEPTH];

    logic [N-1:0] w_addr;
    logic [N-1:0] r_addr;
    logic         w_bank;
    logic         r_bank;
    logic [1:0]   w_quarter;
    logic [1:0]   r_quarter;
    logic         w_behind;
    logic         r_behind;
    logic         dir;
    logic         w_fire;
    logic         r_fire;

    // ========================================================================
    // Bank ownership
    // ========================================================================

    // Top address bit selects the bank, top two the quarter
    assign w_bank    = w_addr[N-1];
    assign r_bank    = r_addr[N-1];
    assign w_quarter = w_addr[N-1:N-2];
    assign r_quarter = r_addr[N-1:N-2];

    // Writer has wrapped around and sits one quarter behind the reader
    assign w_behind = (w_quarter + 2'd1) == r_quarter;

    // Reader trails the writer by one quarter
    assign r_behind = (r_quarter + 2'd1) == w_quarter;

    // Direction flag
    // dir = 0 means a shared bank belongs to the writer
    // dir = 1 means a shared bank holds unread words for the reader
    always_ff @(posedge r_clk or posedge fullish) begin
        if (fullish) begin
            dir <= 1'b0;
        end else if (w_behind) begin
            dir <= 1'b1;
        end else if (r_behind) begin
            dir <= 1'b0;
        end
    end

    // Different banks never conflict
    assign w_ready = (w_bank != r_bank) || !dir;
    assign r_ready = (w_bank != r_bank) || dir;

    // Write position is the first slot of either bank
    assign w_bank_start = w_addr[N-2:0] == '0;

    // ========================================================================
    // Write side
    // ========================================================================

    assign w_fire = w_trigger && w_ready;

    always_ff @(posedge r_clk or posedge fullish) begin
        if (fullish) begin
            w_addr <= '0;
        end else if (w_fire) begin
            w_addr <= w_addr + 1'b1;
        end
    end

    // Storage
    always_ff @(posedge r_clk) begin
        if (w_fire) begin
            mem[w_addr] <= w_data;
        end
    end

    // ========================================================================
    // Read side
    // ========================================================================

    assign r_fire = r_trigger && r_ready;

    always_ff @(posedge r_clk or posedge fullish) begin
        if (fullish) begin
            r_addr <= '0;
        end else if (r_fire) begin
            r_addr <= r_addr + 1'b1;
        end
    end

    // Word at the read address is always visible
    assign r_data = mem[r_addr];

endmodule

`default_nettype wire

// File: verilog/bank_framer.sv
`default_nettype none

`include "capture_cfg.svh"

module bank_framer (
    input  logic                     r_clk,
    input  logic                     fullish,
    input  logic                     r_ready,
    input  capture_pkg::cap_word_t   r_data,
    output logic                     r_trigger,
    input  logic                     out_ready,
    output capture_pkg::frame_beat_t frame_out
);
    import capture_pkg::*;

    // Position within a bank, one bit less than the buffer address
    localparam int POS_W = `CAP_ADDR_W - 1;

    logic [POS_W-1:0] pos_q;
    logic             valid_q;
    logic             start_q;
    logic             last_q;
    cap_word_t        word_q;
    logic             beat_taken;
    logic             can_load;
    logic             at_first;
    logic             at_last;

    // ========================================================================
    // Read control
    // ========================================================================

    // Output beat leaves this cycle
    assign beat_taken = valid_q && out_ready;

    // Register free now or freed by the current transfer
    assign can_load = !valid_q || beat_taken;

    // Read only what the buffer offers
    assign r_trigger = r_ready && can_load;

    // Slot 0 is the header, slot all-ones closes the frame
    assign at_first = pos_q == '0;
    assign at_last  = pos_q == '1;

    // ========================================================================
    // Output register
    // ========================================================================

    always_ff @(posedge r_clk or posedge fullish) begin
        if (fullish) begin
            pos_q   <= '0;
            valid_q <= 1'b0;
            start_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            if (r_trigger) begin
                // Load a new beat, possibly replacing one leaving now
                valid_q <= 1'b1;
                start_q <= at_first;
                last_q  <= at_last;
                pos_q   <= pos_q + 1'b1;
            end else if (beat_taken) begin
                valid_q <= 1'b0;
                start_q <= 1'b0;
                last_q  <= 1'b0;
            end
        end
    end

    // Beat payload holds while stalled
    always_ff @(posedge r_clk) begin
        if (r_trigger) begin
            word_q <= r_data;
        end
    end

    assign frame_out = '{
        valid: valid_q,
        start: start_q,
        last:  last_q,
        word:  word_q
    };

endmodule

`default_nettype wire

// File: verilog/capture_top.sv
`default_nettype none

`include "capture_cfg.svh"

module capture_top (
    input  logic                     r_clk,
    input  logic                     fullish,
    input  capture_pkg::sample_t     sample_in,
    input  logic                     out_ready,
    output capture_pkg::frame_beat_t frame_out
);
    import capture_pkg::*;

    // Packer to buffer
    logic      w_trigger;
    logic      w_ready;
    logic      w_bank_start;
    cap_word_t w_data;

    // Buffer to framer
    logic      r_trigger;
    logic      r_ready;
    cap_word_t r_data;

    // ========================================================================
    // Datapath
    // ========================================================================

    sample_packer u_packer (
        .r_clk        (r_clk),
        .fullish      (fullish),
        .sample_in    (sample_in),
        .w_ready      (w_ready),
        .w_bank_start (w_bank_start),
        .w_trigger    (w_trigger),
        .w_data       (w_data)
    );

    bank_fifo #(
        .W (`CAP_WORD_W),
        .N (`CAP_ADDR_W)
    ) u_fifo (
        .r_clk        (r_clk),
        .fullish      (fullish),
        .w_trigger    (w_trigger),
        .w_data       (w_data),
        .w_ready      (w_ready),
        .w_bank_start (w_bank_start),
        .r_trigger    (r_trigger),
        .r_ready      (r_ready),
        .r_data       (r_data)
    );

    bank_framer u_framer (
        .r_clk     (r_clk),
        .fullish   (fullish),
        .r_ready   (r_ready),
        .r_data    (r_data),
        .r_trigger (r_trigger),
        .out_ready (out_ready),
        .frame_out (frame_out)
    );

endmodule

`default_nettype wire

// File: sim/capture_assertions.sv
`default_nettype none

module capture_assertions (
    input logic                     r_clk,
    input logic                     fullish,
    input logic                     out_ready,
    input capture_pkg::frame_beat_t frame_out
);
    timeunit 1ns;
    timeprecision 1ps;

    // Held beat must not move while the sink stalls
    stall_hold: assert property (
        @(posedge r_clk) disable iff (fullish)
        frame_out.valid && !out_ready |=> $stable(frame_out)
    ) else $error("stalled beat changed before it was taken");

    // Frame markers only ride on a valid beat
    markers_need_valid: assert property (
        @(posedge r_clk) disable iff (fullish)
        (frame_out.start || frame_out.last) |-> frame_out.valid
    ) else $error("start or last seen without valid");

    // Output register cleared while in reset
    reset_clears: assert property (
        @(posedge r_clk)
        fullish |-> !frame_out.valid && !frame_out.start && !frame_out.last
    ) else $error("frame_out not cleared during reset");

endmodule

`default_nettype wire

// File: sim/capture_checker.sv
`default_nettype none

`include "capture_cfg.svh"

module capture_checker (
    input  logic                     r_clk,
    input  logic                     fullish,
    input  capture_pkg::sample_t     sample_in,
    input  logic                     out_ready,
    input  capture_pkg::frame_beat_t frame_out,
    output int                       errors,
    output int                       frames,
    output int                       beats,
    output int                       sat_headers,
    output int                       drop_headers
);
    timeunit 1ns;
    timeprecision 1ps;
    import capture_pkg::*;

    // Header plus payload slots in one bank
    localparam int FRAME_BEATS = 1 << (`CAP_ADDR_W - 1);
    localparam int DROP_MAX    = (1 << `CAP_DROP_W) - 1;

    logic [`CAP_WORD_W-1:0]   sent_q[$];
    logic [`CAP_SAMPLE_W-1:0] held;
    logic                     have_held;
    int                       pos;
    logic [`CAP_SEQ_W-1:0]    exp_seq;
    int                       cur_drops;
    logic                     first_pay;
    logic                     resync;
    logic [`CAP_WORD_W-1:0]   resync_word;

    // Reference pair word, older sample on top
    function automatic logic [`CAP_WORD_W-1:0] pair_word(
        input logic [`CAP_SAMPLE_W-1:0] older,
        input logic [`CAP_SAMPLE_W-1:0] newer
    );
        return {older, newer};
    endfunction

    task automatic report(input string msg);
        errors++;
        $display("** Error at %0d ns: %s", $time, msg);
    endtask

    // Next payload after skipping the pairs the packer dropped
    task automatic take_payload(input logic [`CAP_WORD_W-1:0] got, input int skip);
        logic [`CAP_WORD_W-1:0] want;
        if (sent_q.size() < skip + 1) begin
            report($sformatf("payload %h with only %0d pairs pending", got, sent_q.size()));
        end else begin
            repeat (skip) want = sent_q.pop_front();
            want = sent_q.pop_front();
            if (got !== want) begin
                report($sformatf("payload %h, expected %h", got, want));
            end
        end
    endtask

    // Gap past saturation has unknown length, two payloads locate it
    task automatic resolve_gap(input logic [`CAP_WORD_W-1:0] got);
        int                     i;
        int                     hit;
        logic [`CAP_WORD_W-1:0] gone;
        hit = -1;
        for (i = DROP_MAX; i + 1 < sent_q.size(); i++) begin
            if (hit < 0 && sent_q[i] == resync_word && sent_q[i + 1] == got) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            report($sformatf("payloads %h %h not found past saturated gap", resync_word, got));
        end else begin
            repeat (hit + 2) gone = sent_q.pop_front();
        end
        resync = 1'b0;
    endtask

    task automatic check_beat(input frame_beat_t b);
        beats++;
        if (b.start !== (pos == 0)) begin
            report($sformatf("start %b on beat %0d of a frame", b.start, pos));
        end
        if (b.last !== (pos == FRAME_BEATS - 1)) begin
            report($sformatf("last %b on beat %0d of a frame", b.last, pos));
        end
        if (pos == 0) begin
            if (b.word.hdr.seq !== exp_seq) begin
                report($sformatf("header seq %0d, expected %0d", b.word.hdr.seq, exp_seq));
            end
            exp_seq++;
            cur_drops = int'(b.word.hdr.drops);
            if (cur_drops != 0) drop_headers++;
            if (cur_drops == DROP_MAX) sat_headers++;
            first_pay = 1'b1;
        end else begin
            if (resync) begin
                resolve_gap(b.word);
            end else if (first_pay && cur_drops == DROP_MAX) begin
                resync_word = b.word;
                resync      = 1'b1;
            end else begin
                take_payload(b.word, first_pay ? cur_drops : 0);
            end
            first_pay = 1'b0;
        end
        if (pos == FRAME_BEATS - 1) frames++;
        pos = (pos + 1) % FRAME_BEATS;
    endtask

    always @(posedge r_clk) begin
        if (fullish) begin
            if (frame_out.valid) report("frame_out valid high during reset");
            sent_q.delete();
            have_held = 1'b0;
            pos       = 0;
            exp_seq   = '0;
            first_pay = 1'b0;
            resync    = 1'b0;
        end else begin
            if (sample_in.valid) begin
                if (have_held) sent_q.push_back(pair_word(held, sample_in.data));
                else held = sample_in.data;
                have_held = !have_held;
            end
            if (frame_out.valid && out_ready) check_beat(frame_out);
        end
    end

endmodule

`default_nettype wire

// File: sim/capture_tb.sv
`default_nettype none

`include "capture_cfg.svh"

module capture_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import capture_pkg::*;

    localparam int FRAME_BEATS = 1 << (`CAP_ADDR_W - 1);
    localparam int FRAME_PAIRS = FRAME_BEATS - 1;

    logic        r_clk;
    logic        fullish;
    sample_t     sample_in;
    logic        out_ready;
    frame_beat_t frame_out;

    int          errors;
    int          frames;
    int          beats;
    int          sat_headers;
    int          drop_headers;

    logic [31:0] lfsr;
    int          out_mode;
    logic        timed_out;
    int          tests_run;
    int          tests_failed;

    initial r_clk = 1'b0;
    always #20 r_clk = ~r_clk;

    capture_top dut0 (
        .r_clk     (r_clk),
        .fullish   (fullish),
        .sample_in (sample_in),
        .out_ready (out_ready),
        .frame_out (frame_out)
    );

    capture_checker chk0 (
        .r_clk        (r_clk),
        .fullish      (fullish),
        .sample_in    (sample_in),
        .out_ready    (out_ready),
        .frame_out    (frame_out),
        .errors       (errors),
        .frames       (frames),
        .beats        (beats),
        .sat_headers  (sat_headers),
        .drop_headers (drop_headers)
    );

    // Protocol checks on the framer output
    bind bank_framer capture_assertions u_protocol (
        .r_clk     (r_clk),
        .fullish   (fullish),
        .out_ready (out_ready),
        .frame_out (frame_out)
    );

    // ========================================================================
    // Stimulus helpers
    // ========================================================================

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit collected
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        int         i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // One cycle of stimulus just after the rising edge
    // out_mode picks ready low (0), high (1) or random (2)
    task automatic step(input logic valid, input logic [`CAP_SAMPLE_W-1:0] data);
        logic [7:0] r;
        @(posedge r_clk);
        #1;
        sample_in.valid = valid;
        sample_in.data  = data;
        if (out_mode == 2) begin
            r         = rand_bits(1);
            out_ready = r[0];
        end else begin
            out_ready = (out_mode == 1);
        end
    endtask

    // gap_mode picks back to back (0), every other cycle (1) or random gaps of 0 to 3 (2)
    task automatic send_pairs(input int pairs, input int gap_mode);
        int         n;
        int         g;
        logic [7:0] r;
        for (n = 0; n < 2 * pairs; n++) begin
            step(1'b1, rand_bits(8));
            g = 0;
            if (gap_mode == 1) begin
                g = 1;
            end else if (gap_mode == 2) begin
                r = rand_bits(2);
                g = int'(r);
            end
            repeat (g) step(1'b0, '0);
        end
    endtask

    task automatic wait_frames(input int target, input int limit);
        int c;
        c = 0;
        while (frames < target && c < limit) begin
            step(1'b0, '0);
            c++;
        end
        if (frames < target) begin
            timed_out = 1'b1;
            $display("Timeout: %0d of %0d frames arrived within %0d cycles",
                     frames, target, limit);
        end
    endtask

    task automatic apply_reset();
        fullish   = 1'b1;
        sample_in = '0;
        repeat (2) @(posedge r_clk);
        #1;
        fullish = 1'b0;
    endtask

    task automatic finish_test(input int num, input string name, input int err_before,
                               input logic ok);
        tests_run++;
        if (ok && errors == err_before && !timed_out) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED, %0d check errors", num, name, errors - err_before);
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        int   e;
        int   f0;
        int   b0;
        int   s0;
        int   d0;
        logic held_before;
        lfsr         = 32'hbdaf_9a58;
        out_mode     = 1;
        out_ready    = 1'b0;
        timed_out    = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        apply_reset();

        e  = errors;
        f0 = frames;
        d0 = drop_headers;
        send_pairs(3 * FRAME_PAIRS, 1);
        wait_frames(f0 + 3, 1500);
        finish_test(1, "paced stream in order", e, drop_headers == d0);

        if (!timed_out) begin
            apply_reset();
            e  = errors;
            f0 = frames;
            b0 = beats;
            send_pairs(3 * FRAME_PAIRS, 0);
            wait_frames(f0 + 3, 1500);
            // Quiet window to catch stray beats after the last frame
            repeat (FRAME_BEATS) step(1'b0, '0);
            finish_test(2, "frame shape", e,
                        frames - f0 == 3 && beats - b0 == 3 * FRAME_BEATS);
        end

        if (!timed_out) begin
            apply_reset();
            e        = errors;
            f0       = frames;
            out_mode = 2;
            send_pairs(4 * FRAME_PAIRS, 2);
            wait_frames(f0 + 4, 3000);
            out_mode = 1;
            finish_test(3, "random back-pressure", e, 1'b1);
        end

        if (!timed_out) begin
            apply_reset();
            e        = errors;
            f0       = frames;
            s0       = sat_headers;
            out_mode = 0;
            send_pairs(700, 0);
            out_mode = 1;
            send_pairs(3 * FRAME_PAIRS, 0);
            wait_frames(f0 + 4, 2000);
            finish_test(4, "long stall saturates drops", e, sat_headers > s0);
        end

        if (!timed_out) begin
            apply_reset();
            e        = errors;
            out_mode = 0;
            send_pairs(40, 0);
            held_before = frame_out.valid;
            apply_reset();
            f0       = frames;
            out_mode = 1;
            send_pairs(2 * FRAME_PAIRS, 0);
            wait_frames(f0 + 2, 1000);
            finish_test(5, "reset mid-stream", e, held_before);
        end

        $display("summary: %0d tests run, %0d failed, %0d check errors, %0d frames",
                 tests_run, tests_failed, errors, frames);
        if (tests_failed == 0 && errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/capture_pkg.sv
verilog/sample_packer.sv
verilog/bank_fifo.sv
verilog/bank_framer.sv
verilog/capture_top.sv
sim/capture_assertions.sv
sim/capture_checker.sv
sim/capture_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert -f sim.f --top-module capture_tb \
        -Mdir "$OBJ" -o capture_sim; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/capture_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ "$run_status" -ne 0 ]; then
    echo "Simulation binary exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Simulation passed" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi

exit 0
